// ==== include/logger_config.svh ====
`ifndef LOGGER_CONFIG_SVH
`define LOGGER_CONFIG_SVH

// memory geometry, shrunk for simulation (board uses 23 bits)
`define LOGGER_ADDR_W   5
`define LOGGER_MEM_LAST 31  // cleanup sweeps 0 up to here
`define LOGGER_WORD_W   32

// log region starts at address 0
`define LOGGER_LOG_LAST 15

// first byte of every dumped meter group
`define LOGGER_DUMP_HDR 8'h0A

`endif

// ==== design/logger_pkg.sv ====
package logger_pkg;

	// which engine owns the memory port
	typedef enum logic [2:0] {
		ph_idle,
		ph_cleanup,
		ph_record,
		ph_dump,
		ph_done
	} phase_t;

	typedef enum logic [2:0] {
		main_cleanup,
		main_wait_rec,
		main_record,
		main_wait_dump,
		main_dump,
		main_done,
		main_fault
	} main_state_t;

	typedef enum logic [2:0] {
		cl_write,
		cl_write_wait,
		cl_read,
		cl_check,
		cl_finished,  // also the resting state
		cl_fault
	} cleanup_state_t;

	typedef enum logic [2:0] {
		rec_idle,
		rec_start,
		rec_convert,
		rec_save,
		rec_done
	} rec_state_t;

	typedef enum logic [2:0] {
		dmp_idle,
		dmp_read,
		dmp_wait_word,
		dmp_send,
		dmp_next,
		dmp_done
	} dump_state_t;

	// bit 1 of a log word
	typedef enum logic {
		kind_meter = 1'b0,
		kind_logic = 1'b1  // logic-analyzer words, reserved
	} word_kind_t;

endpackage

// ==== design/mem_cmd_if.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

// one memory client, command side plus read return
interface mem_cmd_if;
	logic                      en;     // one-cycle command strobe
	logic                      wr;     // 1 = write
	logic [`LOGGER_ADDR_W-1:0] addr;
	logic [`LOGGER_WORD_W-1:0] wdata;
	logic                      ready;  // level, low while a command runs
	logic [`LOGGER_WORD_W-1:0] rdata;
	logic                      rvalid; // one-cycle read return

	modport client (
		output en, wr, addr, wdata,
		input  ready, rdata, rvalid
	);

	modport host (
		input  en, wr, addr, wdata,
		output ready, rdata, rvalid
	);
endinterface

// ==== design/mem_port_mux.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module mem_port_mux (
	input  logic                      clk100,
	input  logic                      rst_p,
	input  logger_pkg::phase_t        i_owner,
	mem_cmd_if.host                   cleanup_port,
	mem_cmd_if.host                   record_port,
	mem_cmd_if.host                   dump_port,
	output logic                      o_mem_en,
	output logic                      o_mem_wr,
	output logic [`LOGGER_ADDR_W-1:0] o_mem_addr,
	output logic [`LOGGER_WORD_W-1:0] o_mem_wdata,
	input  logic                      i_mem_ready,
	input  logic [`LOGGER_WORD_W-1:0] i_mem_rdata,
	input  logic                      i_mem_rvalid
);

	logic                      sel_en;
	logic                      sel_wr;
	logic [`LOGGER_ADDR_W-1:0] sel_addr;
	logic [`LOGGER_WORD_W-1:0] sel_wdata;
	logic                      own_cl, own_rec, own_dmp;
	logic                      ready_fwd;

	assign own_cl  = (i_owner == logger_pkg::ph_cleanup);
	assign own_rec = (i_owner == logger_pkg::ph_record);
	assign own_dmp = (i_owner == logger_pkg::ph_dump);

	always_comb begin
		sel_en    = 1'b0;
		sel_wr    = cleanup_port.wr;
		sel_addr  = cleanup_port.addr;
		sel_wdata = cleanup_port.wdata;
		if (own_cl) begin
			sel_en = cleanup_port.en;
		end else if (own_rec) begin
			sel_en    = record_port.en;
			sel_wr    = record_port.wr;
			sel_addr  = record_port.addr;
			sel_wdata = record_port.wdata;
		end else if (own_dmp) begin
			sel_en    = dump_port.en;
			sel_wr    = dump_port.wr;
			sel_addr  = dump_port.addr;
			sel_wdata = dump_port.wdata;
		end
	end

	//////////////////////////////////////////////////
	// command register toward the controller
	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			o_mem_en <= 1'b0;
		end else begin
			o_mem_en <= sel_en;
		end
	end

	always_ff @(posedge clk100) begin
		o_mem_wr    <= sel_wr;
		o_mem_addr  <= sel_addr;
		o_mem_wdata <= sel_wdata;
	end

	// the controller drops ready only after it sees the registered strobe,
	// so hide ready from the client during that one cycle
	assign ready_fwd = i_mem_ready & ~o_mem_en;

	assign cleanup_port.ready  = ready_fwd & own_cl;
	assign cleanup_port.rvalid = i_mem_rvalid & own_cl;
	assign cleanup_port.rdata  = own_cl ? i_mem_rdata : '0;
	assign record_port.ready   = ready_fwd & own_rec;
	assign record_port.rvalid  = i_mem_rvalid & own_rec;
	assign record_port.rdata   = own_rec ? i_mem_rdata : '0;
	assign dump_port.ready     = ready_fwd & own_dmp;
	assign dump_port.rvalid    = i_mem_rvalid & own_dmp;
	assign dump_port.rdata     = own_dmp ? i_mem_rdata : '0;

	// controller must still be ready when the delayed strobe arrives
	a_en_ready: assert property (@(posedge clk100) disable iff (rst_p)
		o_mem_en |-> i_mem_ready);

endmodule

// ==== design/memory_cleanup.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module memory_cleanup (
	input  logic       clk100,
	input  logic       rst_p,
	input  logic       i_go,
	mem_cmd_if.client  mem,
	output logic       o_finished,
	output logic       o_fault
);

	localparam logic [`LOGGER_ADDR_W-1:0] mem_last = `LOGGER_MEM_LAST;

	logger_pkg::cleanup_state_t state;
	logic [`LOGGER_ADDR_W-1:0]  addr;

	// strobe straight from state and ready
	assign mem.en    = ((state == logger_pkg::cl_write) || (state == logger_pkg::cl_read))
		&& mem.ready;
	assign mem.wr    = (state == logger_pkg::cl_write);
	assign mem.addr  = addr;
	assign mem.wdata = '0;

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state      <= logger_pkg::cl_finished;
			addr       <= '0;
			o_finished <= 1'b0;
			o_fault    <= 1'b0;
		end else begin
			o_finished <= 1'b0;
			case (state)
				logger_pkg::cl_finished: begin
					if (i_go) begin
						addr  <= '0;
						state <= logger_pkg::cl_write;
					end
				end
				logger_pkg::cl_write: begin
					if (mem.ready) state <= logger_pkg::cl_write_wait;
				end
				logger_pkg::cl_write_wait: begin
					if (mem.ready) state <= logger_pkg::cl_read; // write done
				end
				logger_pkg::cl_read: begin
					if (mem.ready) state <= logger_pkg::cl_check;
				end
				logger_pkg::cl_check: begin
					if (mem.rvalid) begin
						if (mem.rdata != '0) begin
							o_fault <= 1'b1;
							state   <= logger_pkg::cl_fault;
						end else if (addr == mem_last) begin
							o_finished <= 1'b1;
							state      <= logger_pkg::cl_finished;
						end else begin
							addr  <= addr + 1'b1;
							state <= logger_pkg::cl_write;
						end
					end
				end
				default: ; // fault, frozen until reset
			endcase
		end
	end

	// sweep steps one word at a time and never wraps past the last address
	a_addr_range: assert property (@(posedge clk100) disable iff (rst_p)
		(addr != $past(addr)) && ($past(state) != logger_pkg::cl_finished)
		|-> ($past(addr) != mem_last) && (addr == $past(addr) + 1'b1));

endmodule

// ==== design/sample_recorder.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module sample_recorder (
	input  logic        clk100,
	input  logic        rst_p,
	input  logic        i_go,
	input  logic        i_stop,
	mem_cmd_if.client   mem,
	output logic        o_meter_start,
	input  logic        i_meter_busy,
	input  logic [11:0] i_meter_v,
	input  logic [11:0] i_meter_i,
	output logic        o_finished
);

	localparam logic [`LOGGER_ADDR_W-1:0] log_last = `LOGGER_LOG_LAST;

	logger_pkg::rec_state_t    state;
	logic [`LOGGER_ADDR_W-1:0] addr;
	logic [1:0]                hold;     // busy may lag start by two cycles
	logic                      stop_req;
	logic [`LOGGER_WORD_W-1:0] log_word;
	logic [7:0]                sum;

	assign sum = i_meter_v[11:4] + {i_meter_v[3:0], i_meter_i[11:8]} + i_meter_i[7:0];

	assign mem.en    = (state == logger_pkg::rec_save) && mem.ready;
	assign mem.wr    = 1'b1;
	assign mem.addr  = addr;
	assign mem.wdata = log_word;

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state         <= logger_pkg::rec_idle;
			addr          <= '0;
			hold          <= '0;
			stop_req      <= 1'b0;
			o_meter_start <= 1'b0;
			o_finished    <= 1'b0;
		end else begin
			o_meter_start <= 1'b0;
			o_finished    <= 1'b0;
			if (i_stop) stop_req <= 1'b1;
			case (state)
				logger_pkg::rec_idle: begin
					if (i_go) begin
						addr     <= '0;
						stop_req <= 1'b0;
						state    <= logger_pkg::rec_start;
					end
				end
				logger_pkg::rec_start: begin
					if (stop_req) begin
						state <= logger_pkg::rec_done;
					end else begin
						o_meter_start <= 1'b1;
						hold          <= 2'd2;
						state         <= logger_pkg::rec_convert;
					end
				end
				logger_pkg::rec_convert: begin
					if (hold != 2'd0) begin
						hold <= hold - 1'b1;
					end else if (!i_meter_busy) begin
						state <= stop_req ? logger_pkg::rec_done : logger_pkg::rec_save;
					end
				end
				logger_pkg::rec_save: begin
					if (mem.ready) begin // accepted, next conversion overlaps the write
						if (addr == log_last) begin
							state <= logger_pkg::rec_done;
						end else begin
							addr  <= addr + 1'b1;
							state <= logger_pkg::rec_start;
						end
					end
				end
				default: begin // done, let a write in flight finish
					if (mem.ready) begin
						o_finished <= 1'b1;
						state      <= logger_pkg::rec_idle;
					end
				end
			endcase
		end
	end

	// pack v, i, checksum, kind, valid
	always_ff @(posedge clk100) begin
		if (state == logger_pkg::rec_convert && hold == 2'd0 && !i_meter_busy)
			log_word <= {i_meter_v, i_meter_i, sum[5:0], logger_pkg::kind_meter, 1'b1};
	end

endmodule

// ==== design/serial_dump.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module serial_dump (
	input  logic       clk100,
	input  logic       rst_p,
	input  logic       i_go,
	mem_cmd_if.client  mem,
	input  logic       i_tx_ready,
	output logic       o_tx_en,
	output logic [7:0] o_tx_byte,
	output logic       o_finished
);

	localparam logic [`LOGGER_ADDR_W-1:0] log_last = `LOGGER_LOG_LAST;

	logger_pkg::dump_state_t   state;
	logic [`LOGGER_ADDR_W-1:0] addr;
	logic [`LOGGER_WORD_W-1:0] word;
	logic [2:0]                byte_idx;
	logic                      skip;  // transmitter needs a cycle to drop ready

	assign mem.en    = (state == logger_pkg::dmp_read) && mem.ready;
	assign mem.wr    = 1'b0;
	assign mem.addr  = addr;
	assign mem.wdata = '0;

	assign o_tx_en = (state == logger_pkg::dmp_send) && i_tx_ready && !skip;

	always_comb begin
		case (byte_idx)
			3'd0:    o_tx_byte = `LOGGER_DUMP_HDR;
			3'd1:    o_tx_byte = {4'b0000, word[31:28]};
			3'd2:    o_tx_byte = word[27:20];
			3'd3:    o_tx_byte = {4'b0000, word[19:16]};
			3'd4:    o_tx_byte = word[15:8];
			default: o_tx_byte = {2'b00, word[7:2]}; // checksum
		endcase
	end

	//////////////////////////////////////////////////
	// read one word, send six bytes, move on
	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state      <= logger_pkg::dmp_idle;
			addr       <= '0;
			byte_idx   <= '0;
			skip       <= 1'b0;
			o_finished <= 1'b0;
		end else begin
			o_finished <= 1'b0;
			skip       <= o_tx_en;
			case (state)
				logger_pkg::dmp_idle: begin
					if (i_go) begin
						addr  <= '0;
						state <= logger_pkg::dmp_read;
					end
				end
				logger_pkg::dmp_read: begin
					if (mem.ready) state <= logger_pkg::dmp_wait_word;
				end
				logger_pkg::dmp_wait_word: begin
					if (mem.rvalid) begin
						byte_idx <= '0;
						// valid bit clear marks the end of the log
						state    <= mem.rdata[0] ? logger_pkg::dmp_send : logger_pkg::dmp_done;
					end
				end
				logger_pkg::dmp_send: begin
					if (o_tx_en) begin
						if (byte_idx == 3'd5) state <= logger_pkg::dmp_next;
						else byte_idx <= byte_idx + 1'b1;
					end
				end
				logger_pkg::dmp_next: begin
					if (addr == log_last) begin
						state <= logger_pkg::dmp_done;
					end else begin
						addr  <= addr + 1'b1;
						state <= logger_pkg::dmp_read;
					end
				end
				default: begin
					o_finished <= 1'b1;
					state      <= logger_pkg::dmp_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk100) begin
		if (state == logger_pkg::dmp_wait_word && mem.rvalid) word <= mem.rdata;
	end

	// next word is read only once the previous group is fully out
	a_group_done: assert property (@(posedge clk100) disable iff (rst_p)
		mem.en |-> (addr == '0) || (byte_idx == 3'd5));

endmodule

// ==== design/logger_sequencer.sv ====
`timescale 1ns/1ps

module logger_sequencer (
	input  logic               clk100,
	input  logic               rst_p,
	input  logic               i_button,
	input  logic               i_cleanup_finished,
	input  logic               i_cleanup_fault,
	input  logic               i_record_finished,
	input  logic               i_dump_finished,
	output logic               o_go_cleanup,
	output logic               o_go_record,
	output logic               o_stop_record,
	output logic               o_go_dump,
	output logger_pkg::phase_t o_owner,
	output logic               o_fault,
	output logic               o_done
);

	logger_pkg::main_state_t state;
	logic                    launched; // cleanup kicked off once after reset

	assign o_go_cleanup = (state == logger_pkg::main_cleanup) && !launched;

	always_comb begin
		case (state)
			logger_pkg::main_cleanup: o_owner = logger_pkg::ph_cleanup;
			logger_pkg::main_record:  o_owner = logger_pkg::ph_record;
			logger_pkg::main_dump:    o_owner = logger_pkg::ph_dump;
			logger_pkg::main_done:    o_owner = logger_pkg::ph_done;
			default:                  o_owner = logger_pkg::ph_idle;
		endcase
	end

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state         <= logger_pkg::main_cleanup;
			launched      <= 1'b0;
			o_go_record   <= 1'b0;
			o_stop_record <= 1'b0;
			o_go_dump     <= 1'b0;
			o_fault       <= 1'b0;
			o_done        <= 1'b0;
		end else begin
			launched      <= 1'b1;
			o_go_record   <= 1'b0;
			o_stop_record <= 1'b0;
			o_go_dump     <= 1'b0;
			case (state)
				logger_pkg::main_cleanup: begin // button ignored here
					if (i_cleanup_fault) begin
						o_fault <= 1'b1;
						state   <= logger_pkg::main_fault;
					end else if (i_cleanup_finished) begin
						state <= logger_pkg::main_wait_rec;
					end
				end
				logger_pkg::main_wait_rec: begin
					if (i_button) begin
						o_go_record <= 1'b1;
						state       <= logger_pkg::main_record;
					end
				end
				logger_pkg::main_record: begin
					if (i_record_finished) state <= logger_pkg::main_wait_dump;
					else if (i_button) o_stop_record <= 1'b1;
				end
				logger_pkg::main_wait_dump: begin
					if (i_button) begin
						o_go_dump <= 1'b1;
						state     <= logger_pkg::main_dump;
					end
				end
				logger_pkg::main_dump: begin
					if (i_dump_finished) begin
						o_done <= 1'b1;
						state  <= logger_pkg::main_done;
					end
				end
				default: ; // done or fault, stays until reset
			endcase
		end
	end

	a_one_go: assert property (@(posedge clk100) disable iff (rst_p)
		$onehot0({o_go_cleanup, o_go_record, o_go_dump}));

endmodule

// ==== design/logger_top.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module logger_top (
	input  logic                      clk100,
	input  logic                      rst_p,
	input  logic                      i_button,
	input  logic                      i_mem_ready,
	input  logic [`LOGGER_WORD_W-1:0] i_mem_rdata,
	input  logic                      i_mem_rvalid,
	input  logic                      i_meter_busy,
	input  logic [11:0]               i_meter_v,
	input  logic [11:0]               i_meter_i,
	input  logic                      i_tx_ready,
	output logic                      o_mem_en,
	output logic                      o_mem_wr,
	output logic [`LOGGER_ADDR_W-1:0] o_mem_addr,
	output logic [`LOGGER_WORD_W-1:0] o_mem_wdata,
	output logic                      o_meter_start,
	output logic                      o_tx_en,
	output logic [7:0]                o_tx_byte,
	output logic                      o_fault,
	output logic                      o_done
);

	logic               go_cleanup, go_record, stop_record, go_dump;
	logic               cleanup_finished, cleanup_fault;
	logic               record_finished, dump_finished;
	logger_pkg::phase_t owner;

	mem_cmd_if cleanup_bus ();
	mem_cmd_if record_bus ();
	mem_cmd_if dump_bus ();

	//////////////////////////////////////////////////
	// phase control
	logger_sequencer u_sequencer (
		.clk100             (clk100),
		.rst_p              (rst_p),
		.i_button           (i_button),
		.i_cleanup_finished (cleanup_finished),
		.i_cleanup_fault    (cleanup_fault),
		.i_record_finished  (record_finished),
		.i_dump_finished    (dump_finished),
		.o_go_cleanup       (go_cleanup),
		.o_go_record        (go_record),
		.o_stop_record      (stop_record),
		.o_go_dump          (go_dump),
		.o_owner            (owner),
		.o_fault            (o_fault),
		.o_done             (o_done)
	);

	//////////////////////////////////////////////////
	// phase engines
	memory_cleanup u_cleanup (
		.clk100     (clk100),
		.rst_p      (rst_p),
		.i_go       (go_cleanup),
		.mem        (cleanup_bus.client),
		.o_finished (cleanup_finished),
		.o_fault    (cleanup_fault)
	);

	sample_recorder u_recorder (
		.clk100        (clk100),
		.rst_p         (rst_p),
		.i_go          (go_record),
		.i_stop        (stop_record),
		.mem           (record_bus.client),
		.o_meter_start (o_meter_start),
		.i_meter_busy  (i_meter_busy),
		.i_meter_v     (i_meter_v),
		.i_meter_i     (i_meter_i),
		.o_finished    (record_finished)
	);

	serial_dump u_dump (
		.clk100     (clk100),
		.rst_p      (rst_p),
		.i_go       (go_dump),
		.mem        (dump_bus.client),
		.i_tx_ready (i_tx_ready),
		.o_tx_en    (o_tx_en),
		.o_tx_byte  (o_tx_byte),
		.o_finished (dump_finished)
	);

	// single external memory port
	mem_port_mux u_mux (
		.clk100       (clk100),
		.rst_p        (rst_p),
		.i_owner      (owner),
		.cleanup_port (cleanup_bus.host),
		.record_port  (record_bus.host),
		.dump_port    (dump_bus.host),
		.o_mem_en     (o_mem_en),
		.o_mem_wr     (o_mem_wr),
		.o_mem_addr   (o_mem_addr),
		.o_mem_wdata  (o_mem_wdata),
		.i_mem_ready  (i_mem_ready),
		.i_mem_rdata  (i_mem_rdata),
		.i_mem_rvalid (i_mem_rvalid)
	);

endmodule

// ==== tb/logger_tb_models.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

// memory controller, user side only, with random service time
module mem_model (
	input  logic                      clk100,
	input  logic                      rst_p,
	input  logic                      i_corrupt,
	input  logic                      i_en,
	input  logic                      i_wr,
	input  logic [`LOGGER_ADDR_W-1:0] i_addr,
	input  logic [`LOGGER_WORD_W-1:0] i_wdata,
	output logic                      o_ready,
	output logic [`LOGGER_WORD_W-1:0] o_rdata,
	output logic                      o_rvalid
);
	logic [`LOGGER_WORD_W-1:0] mem [0:`LOGGER_MEM_LAST];
	logic [`LOGGER_ADDR_W-1:0] cmd_addr;
	logic [`LOGGER_WORD_W-1:0] cmd_wdata;
	logic                      cmd_wr;
	logic                      busy;
	int                        dly;
	integer                    seed;

	initial begin
		seed = 32'h19e0_b1df;
		for (int a = 0; a <= `LOGGER_MEM_LAST; a++)
			mem[a] = 32'hc0de_0100 ^ (a * 32'h0101_0101); // never zero
	end

	always @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			o_ready  <= 1'b1;
			o_rdata  <= '0;
			o_rvalid <= 1'b0;
			busy     <= 1'b0;
			dly      <= 0;
		end else begin
			o_rvalid <= 1'b0;
			if (i_en && o_ready) begin
				o_ready   <= 1'b0;
				busy      <= 1'b1;
				cmd_addr  <= i_addr;
				cmd_wr    <= i_wr;
				cmd_wdata <= i_wdata;
				dly       <= 1 + ($random(seed) & 3);
			end else if (busy) begin
				if (dly != 0) begin
					dly <= dly - 1;
				end else if (cmd_wr) begin
					mem[cmd_addr] <= cmd_wdata;
					busy          <= 1'b0;
					o_ready       <= 1'b1;
				end else if (o_rvalid) begin // data went out last cycle
					busy    <= 1'b0;
					o_ready <= 1'b1;
				end else begin
					o_rdata  <= mem[cmd_addr] | ((i_corrupt && cmd_addr == 9) ? 32'h100 : 32'h0);
					o_rvalid <= 1'b1;
				end
			end
		end
	end
endmodule

// meter front end, busy for a random time after each start
module meter_model (
	input  logic       clk100,
	input  logic       rst_p,
	input  logic       i_start,
	output logic       o_busy,
	output logic [4:0] o_idx  // table entry of the current conversion
);
	logic [4:0] next_idx;
	int         cnt;
	integer     seed;

	initial seed = 32'h19e0_b1df;

	always @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			o_busy   <= 1'b0;
			o_idx    <= '0;
			next_idx <= '0;
			cnt      <= 0;
		end else if (i_start) begin
			o_busy   <= 1'b1;
			o_idx    <= next_idx;
			next_idx <= next_idx + 1'b1;
			cnt      <= 1 + ($random(seed) & 3);
		end else if (o_busy) begin
			if (cnt == 0) o_busy <= 1'b0;
			else cnt <= cnt - 1;
		end
	end
endmodule

// serializer, ready drops for a random time after each byte
module tx_model (
	input  logic clk100,
	input  logic rst_p,
	input  logic i_en,
	output logic o_ready
);
	int     cnt;
	integer seed;

	initial seed = 32'h19e0_b1df;

	always @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			o_ready <= 1'b1;
			cnt     <= 0;
		end else if (i_en) begin
			o_ready <= 1'b0;
			cnt     <= $random(seed) & 7;
		end else if (!o_ready) begin
			if (cnt == 0) o_ready <= 1'b1;
			else cnt <= cnt - 1;
		end
	end
endmodule

// ==== tb/logger_tb.sv ====
`timescale 1ns/1ps
`include "logger_config.svh"

module logger_tb;

	localparam int tab_len   = `LOGGER_LOG_LAST + 1;
	localparam int mem_words = `LOGGER_MEM_LAST + 1;
	localparam int cmd_worst = 10; // strobe delay plus longest service time
	localparam int run_cycles = mem_words * 2 * cmd_worst
		+ tab_len * (cmd_worst + 10) + tab_len * (cmd_worst + 6 * 10);
	localparam int watchdog_cycles = 3 * 2 * run_cycles + 500;

	logic                      clk100 = 1'b0;
	logic                      rst_p;
	logic                      i_button;
	logic                      corrupt;
	logic [11:0]               meter_v, meter_i;
	logic                      mem_en, mem_wr, mem_ready, mem_rvalid;
	logic [`LOGGER_ADDR_W-1:0] mem_addr;
	logic [`LOGGER_WORD_W-1:0] mem_wdata, mem_rdata;
	logic                      meter_start, meter_busy;
	logic [4:0]                meter_idx;
	logic                      tx_en, tx_ready;
	logic [7:0]                tx_byte;
	logic                      o_fault, o_done;

	// meter readings, returned one per start
	logic [11:0] v_tab [16] = '{12'h123, 12'hfff, 12'h000, 12'h800, 12'h5a5, 12'ha5a,
		12'h7ff, 12'h001, 12'h3c4, 12'hdef, 12'h246, 12'h9b1, 12'h0f0, 12'hccc, 12'h421, 12'he07};
	logic [11:0] i_tab [16] = '{12'h456, 12'hfff, 12'h000, 12'h001, 12'h3c3, 12'h0ff,
		12'h800, 12'hfee, 12'h777, 12'h135, 12'hb0b, 12'h02c, 12'hf0f, 12'h333, 12'h8a9, 12'h560};

	int         mismatches;
	int         failures;
	int         rec_count;   // log writes seen in the record phase
	int         start_count;
	logic [7:0] rx_bytes [$];

	always #2 clk100 = ~clk100;

	logger_top dut (
		.clk100 (clk100), .rst_p (rst_p), .i_button (i_button),
		.i_mem_ready (mem_ready), .i_mem_rdata (mem_rdata), .i_mem_rvalid (mem_rvalid),
		.i_meter_busy (meter_busy), .i_meter_v (meter_v), .i_meter_i (meter_i),
		.i_tx_ready (tx_ready), .o_mem_en (mem_en), .o_mem_wr (mem_wr),
		.o_mem_addr (mem_addr), .o_mem_wdata (mem_wdata), .o_meter_start (meter_start),
		.o_tx_en (tx_en), .o_tx_byte (tx_byte), .o_fault (o_fault), .o_done (o_done)
	);

	mem_model u_mem (
		.clk100 (clk100), .rst_p (rst_p), .i_corrupt (corrupt), .i_en (mem_en),
		.i_wr (mem_wr), .i_addr (mem_addr), .i_wdata (mem_wdata),
		.o_ready (mem_ready), .o_rdata (mem_rdata), .o_rvalid (mem_rvalid)
	);
	meter_model u_meter (.clk100 (clk100), .rst_p (rst_p), .i_start (meter_start),
		.o_busy (meter_busy), .o_idx (meter_idx));
	tx_model u_tx (.clk100 (clk100), .rst_p (rst_p), .i_en (tx_en), .o_ready (tx_ready));

	// low six bits of the byte sum over the 24-bit reading {v, i}
	function automatic logic [5:0] checksum(input logic [11:0] v, input logic [11:0] i);
		logic [23:0] vi;
		logic [7:0]  s;
		vi = {v, i};
		s  = vi[23:16] + vi[15:8] + vi[7:0];
		return s[5:0];
	endfunction

	function automatic logic [31:0] pack_word(input logic [11:0] v, input logic [11:0] i);
		return {v, i, checksum(v, i), 1'b0, 1'b1}; // meter kind, valid
	endfunction

	// bytes of one dumped group, straight from the reading
	function automatic logic [7:0] group_byte(input logic [11:0] v, input logic [11:0] i,
		input int idx);
		case (idx)
			0:       return `LOGGER_DUMP_HDR;
			1:       return {4'h0, v[11:8]};
			2:       return v[7:0];
			3:       return {4'h0, i[11:8]};
			4:       return i[7:0];
			default: return {2'b00, checksum(v, i)};
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, act, exp);
		end
	endtask

	task automatic fail(input string what);
		failures++;
		$display("Error: %s", what);
	endtask

	//////////////////////////////////////////////////
	// monitors
	always @(posedge clk100) begin
		meter_v <= v_tab[meter_idx[3:0]];
		meter_i <= i_tab[meter_idx[3:0]];
		if (meter_start) start_count++;
		if (tx_en) rx_bytes.push_back(tx_byte);
		if (mem_en && mem_wr && dut.owner == logger_pkg::ph_record) begin
			check("o_mem_addr", 32'(mem_addr), 32'(rec_count));
			check("o_mem_wdata", mem_wdata, pack_word(v_tab[rec_count], i_tab[rec_count]));
			rec_count++;
		end
	end

	task automatic apply_reset(input logic bad_mem);
		@(posedge clk100);
		rst_p   <= 1'b1;
		corrupt <= bad_mem;
		repeat (4) @(posedge clk100);
		rec_count   = 0;
		start_count = 0;
		rx_bytes.delete();
		rst_p <= 1'b0;
	endtask

	task automatic press_button();
		@(posedge clk100);
		i_button <= 1'b1;
		@(posedge clk100);
		i_button <= 1'b0;
	endtask

	// the dump must hold exactly n groups in table order
	task automatic check_dump(input int n);
		check("dump byte count", 32'(rx_bytes.size()), 32'(n * 6));
		for (int k = 0; k < n && (k + 1) * 6 <= rx_bytes.size(); k++) begin
			for (int j = 0; j < 6; j++)
				check("o_tx_byte", 32'(rx_bytes[k * 6 + j]),
					32'(group_byte(v_tab[k], i_tab[k], j)));
		end
	endtask

	task automatic run_to_dump();
		int n;
		press_button(); // dump
		do @(posedge clk100); while (!o_done);
		n = rx_bytes.size();
		repeat (20) @(posedge clk100);
		if (rx_bytes.size() != n) fail("bytes were sent after o_done rose");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial begin
		int nw;
		rst_p      = 1'b1;
		i_button   = 1'b0;
		corrupt    = 1'b0;
		meter_v    = '0;
		meter_i    = '0;
		mismatches = 0;
		failures   = 0;

		// full log, stops by itself
		apply_reset(1'b0);
		do @(posedge clk100); while (!dut.cleanup_finished);
		check("o_fault", 32'(o_fault), 32'h0);
		check("meter starts before button", 32'(start_count), 32'h0);
		check("tx bytes before button", 32'(rx_bytes.size()), 32'h0);
		press_button();
		do @(posedge clk100); while (!dut.record_finished);
		check("log words written", 32'(rec_count), 32'(tab_len));
		run_to_dump();
		check_dump(tab_len);

		// stopped early by the second button
		apply_reset(1'b0);
		do @(posedge clk100); while (!dut.cleanup_finished);
		press_button();
		do @(posedge clk100); while (rec_count < 5);
		press_button();
		do @(posedge clk100); while (!dut.record_finished);
		nw = rec_count;
		if (nw >= tab_len) fail("recording did not stop on the second button");
		run_to_dump();
		check_dump(nw);

		// readback fault during cleanup
		apply_reset(1'b1);
		do @(posedge clk100); while (!o_fault);
		repeat (3) begin
			repeat (10) @(posedge clk100);
			press_button();
		end
		repeat (50) @(posedge clk100);
		check("o_fault", 32'(o_fault), 32'h1);
		check("o_done", 32'(o_done), 32'h0);
		check("meter starts after fault", 32'(start_count), 32'h0);
		check("tx bytes after fault", 32'(rx_bytes.size()), 32'h0);

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk100);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
design/logger_pkg.sv
design/mem_cmd_if.sv
design/mem_port_mux.sv
design/memory_cleanup.sv
design/sample_recorder.sv
design/serial_dump.sv
design/logger_sequencer.sv
design/logger_top.sv
tb/logger_tb_models.sv
tb/logger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the logger testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module logger_tb \
	-o logger_sim > sim.log 2>&1 \
	&& ./obj_dir/logger_sim >> sim.log 2>&1 \
	|| echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
